// ==== rtl/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// word and bus width
`define WORD_W      32

// 2-way, 8 sets, 2 words per block
`define DSETS       8
`define DIDX_W      3
`define DWAYS       2

// address split: tag 31..6, index 5..3, word 2, byte 1..0
`define DTAG_W      26
`define BYTE_OFF_W  2

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_params.svh"

package dcache_pkg;

    // data and address words
    typedef logic [`WORD_W-1:0] word_t;

    // address fields
    typedef logic [`DTAG_W-1:0] dtag_t;
    typedef logic [`DIDX_W-1:0] didx_t;
    typedef logic blkoff_t;     // word within block

    // 0 is way A, 1 is way B
    typedef logic way_t;

    // miss / write-back / flush sequencer
    typedef enum logic [3:0] {
        IDLE,       // lookups, hits served here
        WB1,        // dirty victim, word 0 out
        WB2,        // dirty victim, word 1 out
        FILL1,      // refill word 0
        FILL2,      // refill word 1, tag loaded on the last beat
        FLUSH_CHK,  // look at one way of the flush set
        FLUSH_W1,   // flush write, word 0
        FLUSH_W2    // flush write, word 1
    } ctrl_state_t;

endpackage

// ==== rtl/cache_array_if.sv ====
`timescale 1ns/10ps
`include "dcache_params.svh"

interface cache_array_if import dcache_pkg::*; ();

    // driven by the controller
    didx_t   idx;         // request set or flush set
    way_t    fill_way;    // way being written or evicted
    blkoff_t word_sel;    // word being written or read back
    word_t   wr_data;
    logic    wr_word_en;
    logic    tag_load;    // install new_tag, mark valid and clean
    dtag_t   new_tag;
    logic    clr_dirty;
    logic    clr_valid;   // also drops dirty

    // tag store results
    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    victim_dirty;
    dtag_t   victim_tag;  // tag of fill_way in the selected set
    logic [`DWAYS-1:0] way_dirty;

    // data store result
    word_t   rd_word;

    modport tags (
        input  idx, fill_way, tag_load, new_tag, clr_dirty, clr_valid,
        output hit, hit_way, victim_way, victim_dirty, victim_tag, way_dirty
    );

    modport data (
        input  idx, fill_way, word_sel, wr_data, wr_word_en, hit_way,
        output rd_word
    );

    modport ctrl (
        output idx, fill_way, word_sel, wr_data, wr_word_en,
        output tag_load, new_tag, clr_dirty, clr_valid,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, way_dirty,
        input  rd_word
    );

endinterface

// ==== rtl/dcache_tag_store.sv ====
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  dtag_t req_tag,     // tag field of the datapath address
    input  logic  access,      // read or write request present
    input  logic  write_req,
    cache_array_if.tags arr
);

    // per way, per set
    dtag_t             tags  [`DWAYS][`DSETS];
    logic [`DSETS-1:0] valid [`DWAYS];
    logic [`DSETS-1:0] dirty [`DWAYS];

    // one bit per set, holds the least recently used way
    logic [`DSETS-1:0] lru;

    logic hit_a;
    logic hit_b;

    // compare against both ways of the selected set
    assign hit_a = valid[0][arr.idx] && (tags[0][arr.idx] == req_tag);
    assign hit_b = valid[1][arr.idx] && (tags[1][arr.idx] == req_tag);

    assign arr.hit     = hit_a | hit_b;
    assign arr.hit_way = way_t'(hit_b);  // both can't match, tags unique per set

    // victim is the lru way
    assign arr.victim_way   = lru[arr.idx];
    assign arr.victim_dirty = dirty[lru[arr.idx]][arr.idx];

    // controller points fill_way at the victim or at the flush way
    assign arr.victim_tag = tags[arr.fill_way][arr.idx];

    // flush looks at both ways of the set
    assign arr.way_dirty = {dirty[1][arr.idx], dirty[0][arr.idx]};

    // tag rams, only written on the last refill beat
    always_ff @(posedge CLK) begin
        if (arr.tag_load) begin
            tags[arr.fill_way][arr.idx] <= arr.new_tag;
        end
    end

    // valid, dirty and lru bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '0;  // way A goes first
        end else begin
            // hit access, other way becomes lru
            if (access && arr.hit) begin
                lru[arr.idx] <= ~arr.hit_way;
                if (write_req) begin
                    dirty[arr.hit_way][arr.idx] <= 1'b1;  // write hit
                end
            end

            // refill done, block is clean until the store commits
            if (arr.tag_load) begin
                valid[arr.fill_way][arr.idx] <= 1'b1;
                dirty[arr.fill_way][arr.idx] <= 1'b0;
            end

            // victim written back
            if (arr.clr_dirty) begin
                dirty[arr.fill_way][arr.idx] <= 1'b0;
            end

            // flush drops the block
            if (arr.clr_valid) begin
                valid[arr.fill_way][arr.idx] <= 1'b0;
                dirty[arr.fill_way][arr.idx] <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/dcache_data_store.sv ====
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_data_store import dcache_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  blkoff_t blkoff,    // word field of the datapath address
    output word_t   dmemload,
    cache_array_if.data arr
);

    localparam int BLK_WORDS = 2 ** $bits(blkoff_t);

    // way, set, word
    word_t words [`DWAYS][`DSETS][BLK_WORDS];

    // load path, follows the hit way
    // value is don't care on a miss, dhit qualifies it
    assign dmemload = words[arr.hit_way][arr.idx][blkoff];

    // write-back and flush read port
    assign arr.rd_word = words[arr.fill_way][arr.idx][arr.word_sel];

    // single write port shared by write hits and refill beats
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            words <= '{default: '0};
        end else if (arr.wr_word_en) begin
            words[arr.fill_way][arr.idx][arr.word_sel] <= arr.wr_data;
        end
    end

endmodule

// ==== rtl/dcache_controller.sv ====
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_controller import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // datapath side
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  logic  halt,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    // memory bus side
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait,
    output logic  flushed,
    cache_array_if.ctrl arr
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    // flush walk position
    didx_t flush_idx;
    way_t  flush_way;
    logic  flush_step;   // current flush way done, move on

    // request fields
    dtag_t   req_tag;
    didx_t   req_idx;
    blkoff_t req_off;

    assign req_tag = dmemaddr[`WORD_W-1 -: `DTAG_W];
    assign req_idx = dmemaddr[`BYTE_OFF_W+1 +: `DIDX_W];
    assign req_off = dmemaddr[`BYTE_OFF_W];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_idx <= '0;
            flush_way <= 1'b0;
            flushed   <= 1'b0;
        end else begin
            state <= next_state;
            if (flush_step) begin
                flush_way <= ~flush_way;
                if (flush_way) begin
                    flush_idx <= flush_idx + 1'b1;  // wraps to 0 after the last set
                    if (flush_idx == didx_t'(`DSETS - 1)) begin
                        flushed <= 1'b1;  // sticky until reset
                    end
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        flush_step = 1'b0;

        // bus idle
        dREN   = 1'b0;
        dWEN   = 1'b0;
        daddr  = '0;
        dstore = '0;

        // storage defaults, request set and the lru victim
        arr.idx        = req_idx;
        arr.fill_way   = arr.victim_way;
        arr.word_sel   = req_off;
        arr.wr_data    = dload;
        arr.wr_word_en = 1'b0;
        arr.tag_load   = 1'b0;
        arr.new_tag    = req_tag;
        arr.clr_dirty  = 1'b0;
        arr.clr_valid  = 1'b0;

        case (state)
            IDLE: begin
                // write hit commits this edge
                arr.fill_way   = arr.hit_way;
                arr.wr_data    = dmemstore;
                arr.wr_word_en = dmemWEN && arr.hit;
                if (halt && !flushed) begin
                    next_state = FLUSH_CHK;
                end else if ((dmemREN || dmemWEN) && !arr.hit) begin
                    // clean victim skips write-back
                    next_state = arr.victim_dirty ? WB1 : FILL1;
                end
            end

            WB1: begin
                dWEN         = 1'b1;
                arr.word_sel = 1'b0;
                daddr        = {arr.victim_tag, req_idx, 1'b0, {`BYTE_OFF_W{1'b0}}};
                dstore       = arr.rd_word;
                if (!dwait) begin
                    next_state = WB2;
                end
            end

            WB2: begin
                dWEN         = 1'b1;
                arr.word_sel = 1'b1;
                daddr        = {arr.victim_tag, req_idx, 1'b1, {`BYTE_OFF_W{1'b0}}};
                dstore       = arr.rd_word;
                if (!dwait) begin
                    arr.clr_dirty = 1'b1;
                    next_state    = FILL1;
                end
            end

            FILL1: begin
                dREN           = 1'b1;
                arr.word_sel   = 1'b0;
                daddr          = {req_tag, req_idx, 1'b0, {`BYTE_OFF_W{1'b0}}};
                // write miss merge, store word beats memory word
                arr.wr_data    = (dmemWEN && !req_off) ? dmemstore : dload;
                arr.wr_word_en = !dwait;
                if (!dwait) begin
                    next_state = FILL2;
                end
            end

            FILL2: begin
                dREN           = 1'b1;
                arr.word_sel   = 1'b1;
                daddr          = {req_tag, req_idx, 1'b1, {`BYTE_OFF_W{1'b0}}};
                arr.wr_data    = (dmemWEN && req_off) ? dmemstore : dload;
                arr.wr_word_en = !dwait;
                // tag goes valid with the second word, hit next cycle
                arr.tag_load   = !dwait;
                if (!dwait) begin
                    next_state = IDLE;
                end
            end

            FLUSH_CHK: begin
                arr.idx      = flush_idx;
                arr.fill_way = flush_way;
                if (arr.way_dirty[flush_way]) begin
                    next_state = FLUSH_W1;
                end else begin
                    arr.clr_valid = 1'b1;  // clean way, one cycle
                    flush_step    = 1'b1;
                end
            end

            FLUSH_W1: begin
                arr.idx      = flush_idx;
                arr.fill_way = flush_way;
                arr.word_sel = 1'b0;
                dWEN         = 1'b1;
                daddr        = {arr.victim_tag, flush_idx, 1'b0, {`BYTE_OFF_W{1'b0}}};
                dstore       = arr.rd_word;
                if (!dwait) begin
                    next_state = FLUSH_W2;
                end
            end

            FLUSH_W2: begin
                arr.idx      = flush_idx;
                arr.fill_way = flush_way;
                arr.word_sel = 1'b1;
                dWEN         = 1'b1;
                daddr        = {arr.victim_tag, flush_idx, 1'b1, {`BYTE_OFF_W{1'b0}}};
                dstore       = arr.rd_word;
                if (!dwait) begin
                    arr.clr_valid = 1'b1;
                    flush_step    = 1'b1;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase

        // way B of the last set ends the walk
        if (flush_step) begin
            if (flush_way && (flush_idx == didx_t'(`DSETS - 1))) begin
                next_state = IDLE;
            end else begin
                next_state = FLUSH_CHK;
            end
        end
    end

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // datapath side
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  logic  halt,
    output logic  dhit,
    output word_t dmemload,
    output logic  flushed,
    // memory bus side
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore,
    input  word_t dload,
    input  logic  dwait
);

    cache_array_if arr_if ();

    // combinational hit straight from the tag compare
    assign dhit = arr_if.hit;

    dcache_tag_store u_tags (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_tag   (dmemaddr[`WORD_W-1 -: `DTAG_W]),
        .access    (dmemREN | dmemWEN),
        .write_req (dmemWEN),
        .arr       (arr_if.tags)
    );

    dcache_data_store u_data (
        .CLK      (CLK),
        .nRST     (nRST),
        .blkoff   (dmemaddr[`BYTE_OFF_W]),
        .dmemload (dmemload),
        .arr      (arr_if.data)
    );

    dcache_controller u_ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .halt      (halt),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait),
        .flushed   (flushed),
        .arr       (arr_if.ctrl)
    );

endmodule

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

    localparam int    MEM_WORDS  = 1024;          // word addresses 0x000..0xffc
    localparam word_t MEM_KEY    = 32'h5A5A_0F0F; // preload xor pattern
    localparam int    WAIT_LIMIT = 200;           // cycles allowed per wait loop

    logic  CLK = 1'b0;
    logic  nRST;

    // datapath side
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
    logic  halt;
    logic  dhit;
    word_t dmemload;
    logic  flushed;

    // bus side where the memory model drives dload and dwait
    logic  dREN;
    logic  dWEN;
    word_t daddr;
    word_t dstore;
    word_t dload = '0;
    logic  dwait = 1'b1;

    word_t      mem [MEM_WORDS];
    logic [7:0] lfsr = 8'd12;
    int         stall_left = 0;
    bit         in_beat = 1'b0;
    int         bus_writes = 0;
    int         errors = 0;

    always #4 CLK = ~CLK;  // 8 ns period

    dcache uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (daddr),
        .dstore    (dstore),
        .dload     (dload),
        .dwait     (dwait)
    );

    // galois lfsr with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 8'hB8;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // memory model moves everything on the falling edge
    always @(negedge CLK) begin
        if (!nRST) begin
            dwait   = 1'b1;
            in_beat = 1'b0;
        end else if (dREN || dWEN) begin
            if (dREN && dWEN) begin
                $display("ERROR: dREN and dWEN are high together at %0t", $time);
                errors++;
            end
            if (!in_beat) begin
                in_beat    = 1'b1;
                stall_left = 0;
                repeat (2) begin  // 2 bits give 0 to 3 wait cycles
                    lfsr       = lfsr_step(lfsr);
                    stall_left = stall_left * 2 + int'(lfsr[0]);
                end
            end
            dload = mem[daddr[11:2]];
            if (stall_left > 0) begin
                dwait = 1'b1;
                stall_left--;
            end else begin
                dwait   = 1'b0;  // beat ends at the next rising edge
                in_beat = 1'b0;
                if (dWEN) begin
                    mem[daddr[11:2]] = dstore;
                    bus_writes++;
                end
            end
        end else begin
            dwait = 1'b1;
        end
    end

    // one request held through the first hit edge so stores and lru commit
    task automatic cache_access(input bit is_write, input word_t addr, input word_t data,
                                output word_t rdata, output bit ok);
        int cycles;
        @(negedge CLK);
        dmemREN   = !is_write;
        dmemWEN   = is_write;
        dmemaddr  = addr;
        dmemstore = data;
        cycles    = 0;
        ok        = 1'b0;
        rdata     = '0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
            if (dhit) begin
                ok    = 1'b1;
                rdata = dmemload;
            end
        end
        if (ok) begin
            @(negedge CLK);  // hit edge passed
        end else begin
            $display("ERROR: dhit never rose within %0d cycles for address %h", WAIT_LIMIT, addr);
        end
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
    endtask

    task automatic run_flush(output bit ok);
        int cycles;
        @(negedge CLK);
        halt   = 1'b1;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
            ok = flushed;
        end
        if (!ok) begin
            $display("ERROR: flushed never rose within %0d cycles after halt", WAIT_LIMIT);
        end
        halt = 1'b0;
    endtask

    initial begin
        string line;
        string op;
        string name;
        int    fd;
        int    nf;
        int    start_errors;
        int    writes_before;
        int    n_pass;
        int    n_fail;
        word_t addr;
        word_t data;
        word_t expected;
        word_t rdata;
        bit    ok;
        bit    abort;

        nRST      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        halt      = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        abort     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i << 2) ^ MEM_KEY;  // byte address xor key
        end

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        fd = $fopen("testbench/dcache_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open testbench/dcache_cases.txt");
            abort = 1'b1;
        end

        while (!abort && !$feof(fd)) begin
            line = "";
            nf = $fgets(line, fd);
            if (nf == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;  // comment, blank or end of file
            end
            nf = $sscanf(line, "%s %h %h %h %s", op, addr, data, expected, name);
            if (nf != 5) begin
                $display("ERROR: malformed case line: %s", line);
                n_fail++;
                continue;
            end
            start_errors = errors;
            ok = 1'b1;
            if (op == "read") begin
                cache_access(1'b0, addr, data, rdata, ok);
                if (ok) begin
                    check_value(name, expected, rdata);
                end
            end else if (op == "write") begin
                cache_access(1'b1, addr, data, rdata, ok);
                if (ok) begin
                    check_value(name, data, rdata);  // load port shows the stored word
                end
            end else if (op == "halt") begin
                writes_before = bus_writes;
                run_flush(ok);
                if (ok) begin
                    check_value(name, expected, word_t'(bus_writes - writes_before));
                end
            end else if (op == "memchk") begin
                check_value(name, expected, mem[addr[11:2]]);
            end else begin
                $display("ERROR: unknown operation %s in test %s", op, name);
                errors++;
            end

            if (!ok) begin
                $display("FAIL %s (timed out, remaining cases skipped)", name);
                n_fail++;
                abort = 1'b1;
            end else if (errors != start_errors) begin
                $display("FAIL %s", name);
                n_fail++;
            end else begin
                $display("PASS %s", name);
                n_pass++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("cases run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && errors == 0 && !abort && n_pass > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/dcache_cases.txt ====
# op addr data expected name (hex fields; write ignores expected, halt expects flush bus writes)
# memory preload at each word is its byte address xor 5a5a0f0f
read   00000040 00000000 5a5a0f4f rd_miss_set0
read   00000040 00000000 5a5a0f4f rd_hit_set0
write  00000044 11112222 11112222 wr_hit_set0
read   00000044 00000000 11112222 rd_after_wr
read   00000040 00000000 5a5a0f4f rd_other_word
write  00000088 cafe0001 cafe0001 wr_miss_set1
read   00000088 00000000 cafe0001 merge_store_word
read   0000008c 00000000 5a5a0f83 merge_mem_word
write  00000110 dead0010 dead0010 wr_miss_tag4_set2
read   00000150 00000000 5a5a0e5f rd_miss_tag5_set2
read   00000190 00000000 5a5a0e9f rd_miss_tag6_evicts_tag4
memchk 00000110 00000000 dead0010 evict_wb_word0
memchk 00000114 00000000 5a5a0e1b evict_wb_word1
read   00000110 00000000 dead0010 reread_evicted
read   00000114 00000000 5a5a0e1b reread_evicted_word1
write  0000003c 0badf00d 0badf00d wr_miss_set7
write  00000038 77778888 77778888 wr_hit_set7
read   0000003c 00000000 0badf00d other_word_kept_set7
read   00000038 00000000 77778888 rd_after_wr_set7
halt   00000000 00000000 00000006 flush_dirty_writes
memchk 00000040 00000000 5a5a0f4f flushed_set0_word0
memchk 00000044 00000000 11112222 flushed_set0_word1
memchk 00000088 00000000 cafe0001 flushed_set1_word0
memchk 0000008c 00000000 5a5a0f83 flushed_set1_word1
memchk 00000038 00000000 77778888 flushed_set7_word0
memchk 0000003c 00000000 0badf00d flushed_set7_word1
memchk 00000110 00000000 dead0010 set2_unchanged
read   00000044 00000000 11112222 rd_after_flush

// ==== sources.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/cache_array_if.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_controller.sv
rtl/dcache.sv
testbench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
